// ==== source/fetch_pkg.sv ====
package fetch_pkg;

    // plain vector widths
    typedef logic [31:0] addr_t;     // virtual or physical address
    typedef logic [31:0] inst_t;     // one instruction word
    typedef logic [19:0] vppn_t;     // vaddr[31:12], one page per entry
    typedef logic [19:0] ppn_t;      // physical page number
    typedef logic [2:0]  seg_t;      // address bits 31:29
    typedef logic [3:0]  tlb_idx_t;  // covers 16 entries

    typedef enum logic {
        ps_4k = 1'b0,
        ps_4m = 1'b1
    } page_size_t;

    // first sequential fetch lands on 32'h1c000000
    localparam addr_t RESET_PC = 32'h1bfffffc;

    // branch from decode or flush from writeback
    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

    // direct map window fields from the CSR file
    typedef struct packed {
        logic plv_met;   // current privilege allowed by the window
        seg_t vseg;
        seg_t pseg;
    } dmw_t;

    typedef struct packed {
        tlb_idx_t   index;
        vppn_t      vppn;
        ppn_t       ppn;
        page_size_t ps;
    } tlb_fill_t;

    typedef struct packed {
        logic       found;
        ppn_t       ppn;
        page_size_t ps;
    } tlb_result_t;

    // fetch to decode payload
    typedef struct packed {
        inst_t inst;
        addr_t pc;
        logic  excep_adef;   // misaligned fetch address
        logic  excep_tlbr;   // tlb refill, no mapping found
    } fetch_out_t;

endpackage

// ==== source/inst_tlb.sv ====
`timescale 1ns/1ps

module inst_tlb import fetch_pkg::*; #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        fill_en,
    input  tlb_fill_t   fill,
    input  addr_t       vaddr,
    output tlb_result_t result
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    logic [TLB_ENTRIES-1:0] ent_valid;
    vppn_t                  ent_vppn [TLB_ENTRIES];
    ppn_t                   ent_ppn  [TLB_ENTRIES];
    page_size_t             ent_ps   [TLB_ENTRIES];

    logic [IDX_W-1:0]       fill_idx;
    vppn_t                  look_vppn;
    logic [TLB_ENTRIES-1:0] hit;

    assign fill_idx  = fill.index[IDX_W-1:0];
    assign look_vppn = vaddr[31:12];

    // valid bits are the only state cleared by reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ent_valid <= '0;
        end else if (fill_en) begin
            ent_valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            ent_vppn[fill_idx] <= fill.vppn;
            ent_ppn[fill_idx]  <= fill.ppn;
            ent_ps[fill_idx]   <= fill.ps;
        end
    end

    // per entry compare, 4m pages ignore vaddr[21:12]
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (ent_ps[i] == ps_4m) begin
                hit[i] = ent_valid[i] && (ent_vppn[i][19:10] == look_vppn[19:10]);
            end else begin
                hit[i] = ent_valid[i] && (ent_vppn[i] == look_vppn);
            end
        end
    end

    // walk downwards so the lowest matching index is the one left standing
    always_comb begin
        result.found = 1'b0;
        result.ppn   = '0;
        result.ps    = ps_4k;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                result.found = 1'b1;
                result.ppn   = ent_ppn[i];
                result.ps    = ent_ps[i];
            end
        end
    end

endmodule

// ==== source/fetch_xlate.sv ====
`timescale 1ns/1ps

module fetch_xlate import fetch_pkg::*; (
    input  addr_t       vaddr,
    input  logic        paging,
    input  dmw_t        dmw0,
    input  dmw_t        dmw1,
    input  tlb_result_t tlb_res,
    output addr_t       paddr,
    output logic        tlb_miss
);

    seg_t vseg;
    logic hit_dmw0;
    logic hit_dmw1;

    assign vseg     = vaddr[31:29];
    assign hit_dmw0 = dmw0.plv_met && (dmw0.vseg == vseg);
    assign hit_dmw1 = dmw1.plv_met && (dmw1.vseg == vseg);

    // windows take priority over the tlb, window 0 over window 1
    always_comb begin
        if (!paging) begin
            paddr = vaddr;                                   // direct mode
        end else if (hit_dmw0) begin
            paddr = {dmw0.pseg, vaddr[28:0]};
        end else if (hit_dmw1) begin
            paddr = {dmw1.pseg, vaddr[28:0]};
        end else if (tlb_res.found && tlb_res.ps == ps_4m) begin
            paddr = {tlb_res.ppn[19:10], vaddr[21:0]};     // 4m page
        end else begin
            paddr = {tlb_res.ppn, vaddr[11:0]};            // 4k page, or junk on miss
        end
    end

    // a miss still issues the request, decode sees the tag
    assign tlb_miss = paging && !hit_dmw0 && !hit_dmw1 && !tlb_res.found;

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    output logic       inst_req,
    output addr_t      inst_addr,
    input  logic       inst_addr_ok,
    input  logic       inst_data_ok,
    input  inst_t      inst_rdata,
    input  redirect_t  br,
    input  logic       br_stall,
    input  redirect_t  flush,
    input  logic       id_allowin,
    output logic       out_valid,
    output fetch_out_t out_bus,
    output addr_t      pre_pc,
    input  addr_t      paddr,
    input  logic       tlb_miss
);

    logic       fetch_on;       // requests start one cycle after reset release
    logic       req_accept;
    logic       redirect;
    logic [1:0] inflight;       // accepted requests not yet returned
    logic [1:0] cancel_cnt;     // stale returns still to drop
    logic       data_live;
    logic       data_to_if;
    logic       data_to_pre;

    logic       flush_q;
    addr_t      flush_target_q;
    logic       br_q;
    addr_t      br_target_q;
    logic       pre_adef;

    logic       pre_reqed;      // pre-fetch slot holds an accepted request
    logic       pre_ir_valid;
    inst_t      pre_ir;
    addr_t      pre_req_pc;
    logic       pre_req_adef;
    logic       pre_req_tlbr;
    logic       from_req;       // fetch slot is fed straight from this cycle's request
    logic       pre_ready_go;
    logic       move;

    logic       if_valid;
    logic       if_ir_valid;
    inst_t      if_ir;
    addr_t      if_pc;
    logic       if_adef;
    logic       if_tlbr;
    logic       if_wait;
    logic       if_ready_go;
    logic       if_allowin;

    assign req_accept = inst_req & inst_addr_ok;
    assign redirect   = br.taken | flush.taken;
    assign inst_req   = fetch_on & ~pre_reqed & ~br_stall & (inflight != 2'd2);
    assign inst_addr  = paddr;

    // captured flush, live flush, captured branch, live branch, sequential
    always_comb begin
        if (flush_q) begin
            pre_pc = flush_target_q;
        end else if (flush.taken) begin
            pre_pc = flush.target;
        end else if (br_q) begin
            pre_pc = br_target_q;
        end else if (br.taken) begin
            pre_pc = br.target;
        end else begin
            pre_pc = if_pc + 32'd4;
        end
    end
    assign pre_adef = |pre_pc[1:0];

    // returns are in order, so the fetch slot's word comes back first
    assign data_live   = inst_data_ok & (cancel_cnt == 2'd0) & ~redirect;
    assign if_wait     = if_valid & ~if_ir_valid;
    assign data_to_if  = data_live & if_wait;
    assign data_to_pre = data_live & ~if_wait;

    assign if_ready_go  = if_ir_valid | data_to_if;
    assign if_allowin   = ~if_valid | (if_ready_go & id_allowin);
    assign from_req     = redirect | ~pre_reqed;    // redirect drops the old slot
    assign pre_ready_go = from_req ? req_accept : 1'b1;
    assign move         = pre_ready_go & (redirect | if_allowin);

    assign out_valid          = if_valid & if_ready_go & ~redirect;
    assign out_bus.inst       = if_ir_valid ? if_ir : inst_rdata;
    assign out_bus.pc         = if_pc;
    assign out_bus.excep_adef = if_adef;
    assign out_bus.excep_tlbr = if_tlbr;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_on   <= 1'b0;
            inflight   <= 2'd0;
            cancel_cnt <= 2'd0;
        end else begin
            fetch_on <= 1'b1;
            inflight <= inflight + {1'b0, req_accept} - {1'b0, inst_data_ok};
            if (redirect) begin
                cancel_cnt <= inflight - {1'b0, inst_data_ok};    // all older returns are stale
            end else if (inst_data_ok && cancel_cnt != 2'd0) begin
                cancel_cnt <= cancel_cnt - 2'd1;
            end
        end
    end

    // hold a redirect until its request is accepted
    always_ff @(posedge clk) begin
        if (!resetn) begin
            flush_q <= 1'b0;
            br_q    <= 1'b0;
        end else begin
            if (flush.taken && !req_accept) begin
                flush_q <= 1'b1;
            end else if (req_accept) begin
                flush_q <= 1'b0;
            end
            if (br.taken && !flush.taken && !req_accept) begin
                br_q <= 1'b1;
            end else if (req_accept || flush.taken) begin
                br_q <= 1'b0;   // flush kills a pending branch
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush.taken) begin
            flush_target_q <= flush.target;
        end
        if (br.taken) begin
            br_target_q <= br.target;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_reqed    <= 1'b0;
            pre_ir_valid <= 1'b0;
        end else if (redirect || move) begin
            pre_reqed    <= 1'b0;
            pre_ir_valid <= 1'b0;
        end else begin
            if (req_accept) begin
                pre_reqed <= 1'b1;      // fetch slot busy, park the request here
            end
            if (data_to_pre) begin
                pre_ir_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            pre_req_pc   <= pre_pc;
            pre_req_adef <= pre_adef;
            pre_req_tlbr <= tlb_miss;
        end
        if (data_to_pre) begin
            pre_ir <= inst_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid    <= 1'b0;
            if_ir_valid <= 1'b0;
            if_pc       <= RESET_PC;
        end else if (move) begin
            if_valid    <= 1'b1;
            if_ir_valid <= ~from_req & (pre_ir_valid | data_to_pre);
            if_pc       <= from_req ? pre_pc : pre_req_pc;
        end else if (redirect || (if_ready_go && id_allowin)) begin
            if_valid    <= 1'b0;
            if_ir_valid <= 1'b0;
        end else if (data_to_if) begin
            if_ir_valid <= 1'b1;        // decode stalled, keep the word
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            if_adef <= from_req ? pre_adef : pre_req_adef;
            if_tlbr <= from_req ? tlb_miss : pre_req_tlbr;
            if_ir   <= pre_ir_valid ? pre_ir : inst_rdata;
        end else if (data_to_if) begin
            if_ir <= inst_rdata;
        end
    end

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic       clk,
    input  logic       resetn,
    output logic       inst_req,
    output addr_t      inst_addr,
    input  logic       inst_addr_ok,
    input  logic       inst_data_ok,
    input  inst_t      inst_rdata,
    input  redirect_t  br,
    input  logic       br_stall,
    input  redirect_t  flush,
    input  logic       id_allowin,
    output logic       out_valid,
    output fetch_out_t out_bus,
    input  logic       csr_pg,
    input  dmw_t       dmw0,
    input  dmw_t       dmw1,
    input  logic       tlb_fill_en,
    input  tlb_fill_t  tlb_fill
);

    addr_t       pre_pc;
    addr_t       paddr;
    logic        tlb_miss;
    tlb_result_t tlb_res;

    fetch_stage i_stage (
        .clk          (clk),
        .resetn       (resetn),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .br           (br),
        .br_stall     (br_stall),
        .flush        (flush),
        .id_allowin   (id_allowin),
        .out_valid    (out_valid),
        .out_bus      (out_bus),
        .pre_pc       (pre_pc),
        .paddr        (paddr),
        .tlb_miss     (tlb_miss)
    );

    fetch_xlate i_xlate (
        .vaddr    (pre_pc),
        .paging   (csr_pg),
        .dmw0     (dmw0),
        .dmw1     (dmw1),
        .tlb_res  (tlb_res),
        .paddr    (paddr),
        .tlb_miss (tlb_miss)
    );

    inst_tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_tlb (
        .clk     (clk),
        .resetn  (resetn),
        .fill_en (tlb_fill_en),
        .fill    (tlb_fill),
        .vaddr   (pre_pc),       // lookup runs in parallel with the windows
        .result  (tlb_res)
    );

endmodule

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam int    STEP_LIMIT = 400;            // cycles allowed per trace step
    localparam int    TLB_N      = 16;
    localparam addr_t BOOT_PC    = 32'h1c000000;   // first fetch after reset

    logic       clk;
    logic       resetn;
    logic       inst_req;
    addr_t      inst_addr;
    logic       inst_addr_ok;
    logic       inst_data_ok;
    inst_t      inst_rdata;
    redirect_t  br;
    logic       br_stall;
    redirect_t  flush;
    logic       id_allowin;
    logic       out_valid;
    fetch_out_t out_bus;
    logic       csr_pg;
    dmw_t       dmw0;
    dmw_t       dmw1;
    logic       tlb_fill_en;
    tlb_fill_t  tlb_fill;

    integer     seed = 32'h89c6;
    int         mismatches = 0;
    int         other_errors = 0;
    logic [1:0] stall;              // decode stall chance in quarters
    int         stall_rnd;          // decode stall draw, one cycle old
    bit         first_seen;

    // reference model state
    logic       cur_pg;
    dmw_t       cur_dmw0;
    dmw_t       cur_dmw1;
    logic       m_valid [TLB_N];
    vppn_t      m_vppn [TLB_N];
    ppn_t       m_ppn [TLB_N];
    page_size_t m_ps [TLB_N];

    fetch_out_t exp_q [$];
    bit         chk_q [$];          // inst compare wanted
    addr_t      mem_addr_q [$];
    int         mem_due_q [$];
    int         cycle;

    fetch_top #(.TLB_ENTRIES(TLB_N)) i_dut (
        .clk(clk), .resetn(resetn),
        .inst_req(inst_req), .inst_addr(inst_addr), .inst_addr_ok(inst_addr_ok),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .br(br), .br_stall(br_stall), .flush(flush),
        .id_allowin(id_allowin), .out_valid(out_valid), .out_bus(out_bus),
        .csr_pg(csr_pg), .dmw0(dmw0), .dmw1(dmw1),
        .tlb_fill_en(tlb_fill_en), .tlb_fill(tlb_fill)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic compare_pc(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Mismatch out_bus.pc at first fetch: got %h expected %h", got, exp);
            mismatches++;
        end
    endtask

    task automatic compare_fetch(input fetch_out_t got, input fetch_out_t exp, input bit chk);
        if (got.pc !== exp.pc) begin
            $display("Mismatch out_bus.pc: got %h expected %h", got.pc, exp.pc);
            mismatches++;
        end
        if (chk && got.inst !== exp.inst) begin
            $display("Mismatch out_bus.inst: got %h expected %h", got.inst, exp.inst);
            mismatches++;
        end
        if (got.excep_adef !== exp.excep_adef) begin
            $display("Mismatch out_bus.excep_adef: got %h expected %h",
                     got.excep_adef, exp.excep_adef);
            mismatches++;
        end
        if (got.excep_tlbr !== exp.excep_tlbr) begin
            $display("Mismatch out_bus.excep_tlbr: got %h expected %h",
                     got.excep_tlbr, exp.excep_tlbr);
            mismatches++;
        end
    endtask

    // windows first and then the lowest matching tlb entry
    function automatic addr_t expect_paddr(input addr_t va);
        addr_t pa;
        pa = va;
        if (cur_pg && cur_dmw0.plv_met && cur_dmw0.vseg == va[31:29]) begin
            pa = {cur_dmw0.pseg, va[28:0]};
        end else if (cur_pg && cur_dmw1.plv_met && cur_dmw1.vseg == va[31:29]) begin
            pa = {cur_dmw1.pseg, va[28:0]};
        end else if (cur_pg) begin
            for (int i = TLB_N - 1; i >= 0; i--) begin
                if (m_valid[i] && m_ps[i] == ps_4m && m_vppn[i][19:10] == va[31:22]) begin
                    pa = {m_ppn[i][19:10], va[21:0]};
                end else if (m_valid[i] && m_ps[i] == ps_4k && m_vppn[i] == va[31:12]) begin
                    pa = {m_ppn[i], va[11:0]};
                end
            end
        end
        return pa;
    endfunction

    // memory model returns in order after 1 to 3 cycles
    always @(posedge clk) begin
        int rnd;
        rnd = $random(seed);
        stall_rnd <= $random(seed);
        cycle++;
        inst_data_ok <= 1'b0;
        if (!resetn) begin
            inst_addr_ok <= 1'b0;
            mem_addr_q.delete();
            mem_due_q.delete();
        end else begin
            if (inst_req && inst_addr_ok) begin
                mem_addr_q.push_back(inst_addr);
                mem_due_q.push_back(cycle + 1 + (rnd & 32'h7fffffff) % 3);
            end
            if (mem_due_q.size() != 0 && cycle >= mem_due_q[0]) begin
                inst_data_ok <= 1'b1;
                inst_rdata   <= mem_addr_q.pop_front() ^ 32'h5a5a0000;
                void'(mem_due_q.pop_front());
            end
            inst_addr_ok <= rnd[4];
        end
    end

    // decode side checks transfers and drives allowin
    always @(posedge clk) begin
        if (resetn && out_valid && id_allowin) begin
            if (exp_q.size() == 0) begin
                $display("decode link delivered pc %h with nothing expected", out_bus.pc);
                other_errors++;
            end else begin
                if (!first_seen) compare_pc(out_bus.pc, BOOT_PC);
                compare_fetch(out_bus, exp_q.pop_front(), chk_q.pop_front());
            end
            first_seen = 1'b1;
        end
        if (!resetn || exp_q.size() == 0) begin
            id_allowin <= 1'b0;
        end else begin
            id_allowin <= !(stall != 2'd0 && stall_rnd[1:0] < stall);
        end
    end

    initial begin
        int          fd;
        int          n;
        int          step;
        int          wc;
        bit          timed_out;
        string       line;
        fetch_out_t  e;
        logic [31:0] f_pg;
        logic [31:0] f_d0;
        logic [31:0] f_d1;
        logic [31:0] f_fill;
        logic [31:0] f_idx;
        logic [31:0] f_vppn;
        logic [31:0] f_ppn;
        logic [31:0] f_ps;
        logic [31:0] f_kind;
        logic [31:0] f_btgt;
        logic [31:0] f_ftgt;
        logic [31:0] f_stall;
        logic [31:0] f_cnt;
        logic [31:0] f_pc;
        logic [31:0] f_tags;
        step = 0;
        timed_out = 1'b0;
        first_seen = 1'b0;
        cycle = 0;
        for (int i = 0; i < TLB_N; i++) m_valid[i] = 1'b0;
        cur_pg = 1'b0;
        cur_dmw0 = '0;
        cur_dmw1 = '0;
        resetn <= 1'b0;
        inst_addr_ok <= 1'b0;
        inst_data_ok <= 1'b0;
        inst_rdata <= '0;
        br <= '0;
        br_stall <= 1'b0;
        flush <= '0;
        id_allowin <= 1'b0;
        csr_pg <= 1'b0;
        dmw0 <= '0;
        dmw1 <= '0;
        tlb_fill_en <= 1'b0;
        tlb_fill <= '0;
        stall <= 2'd0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        fd = $fopen("dv/fetch_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            other_errors++;
        end
        while (fd != 0 && !$feof(fd) && !timed_out) begin
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f_pg, f_d0, f_d1, f_fill, f_idx, f_vppn, f_ppn, f_ps,
                        f_kind, f_btgt, f_ftgt, f_stall, f_cnt, f_pc, f_tags);
            if (n != 15) begin
                $display("trace line %0d is malformed", step);
                other_errors++;
                continue;
            end
            @(posedge clk);
            if (f_fill[0]) begin
                tlb_fill_en <= 1'b1;
                tlb_fill <= '{index: f_idx[3:0], vppn: f_vppn[19:0], ppn: f_ppn[19:0],
                               ps: page_size_t'(f_ps[0])};
                m_valid[f_idx[3:0]] = 1'b1;
                m_vppn[f_idx[3:0]] = f_vppn[19:0];
                m_ppn[f_idx[3:0]] = f_ppn[19:0];
                m_ps[f_idx[3:0]] = page_size_t'(f_ps[0]);
                @(posedge clk);
                tlb_fill_en <= 1'b0;
            end
            // new settings go live with the redirect and stale requests are dropped
            cur_pg = f_pg[0];
            cur_dmw0 = f_d0[6:0];
            cur_dmw1 = f_d1[6:0];
            csr_pg <= f_pg[0];
            dmw0 <= f_d0[6:0];
            dmw1 <= f_d1[6:0];
            br <= '{taken: f_kind[0], target: f_btgt};
            flush <= '{taken: f_kind[1], target: f_ftgt};
            stall <= f_stall[1:0];
            for (int k = 0; k < int'(f_cnt); k++) begin
                e.pc = f_pc + (k << 2);
                e.inst = expect_paddr(e.pc) ^ 32'h5a5a0000;
                e.excep_adef = f_tags[1];
                e.excep_tlbr = f_tags[0];
                exp_q.push_back(e);
                chk_q.push_back(!f_tags[0]);    // miss word is junk
            end
            @(posedge clk);
            br <= '0;
            flush <= '0;
            wc = 0;
            while (exp_q.size() != 0 && !timed_out) begin
                @(negedge clk);
                wc++;
                if (wc > STEP_LIMIT) begin
                    $display("timeout in step %0d, %0d instructions never arrived",
                             step, exp_q.size());
                    other_errors++;
                    timed_out = 1'b1;
                end
            end
            step++;
        end
        if (fd != 0) $fclose(fd);
        $display("steps %0d, mismatches %0d, other errors %0d", step, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== dv/fetch_trace.txt ====
# pg dmw0 dmw1 fill idx vppn ppn ps kind br_target flush_target stall count first_pc tags
# kind: 0 none, 1 branch, 2 flush, 3 both; tags: 2 adef, 1 tlbr; all fields hex
# after reset, paging off, sequential stream
0 00 00 0 0 00000 00000 0 0 00000000 00000000 0 8 1c000000 0
# sequential stream continues under random decode stalls
0 00 00 0 0 00000 00000 0 0 00000000 00000000 2 c 1c000020 0
# branch redirect
0 00 00 0 0 00000 00000 0 1 1c000400 00000000 0 6 1c000400 0
# flush redirect with light stalls
0 00 00 0 0 00000 00000 0 2 00000000 1c008000 1 6 1c008000 0
# branch and flush together, flush wins
0 00 00 0 0 00000 00000 0 3 1c001000 1c00f000 0 5 1c00f000 0
# branch under heavy stalls, then carry on
0 00 00 0 0 00000 00000 0 1 1c000100 00000000 3 a 1c000100 0
0 00 00 0 0 00000 00000 0 0 00000000 00000000 1 8 1c000128 0
# paging on, window 0 maps segment 4 to 0
1 60 68 0 0 00000 00000 0 2 00000000 80001000 0 6 80001000 0
# window 1 maps segment 5 to 0
1 60 68 0 0 00000 00000 0 2 00000000 a0002000 2 6 a0002000 0
# 4k page in entry 1
1 60 68 1 1 00400 1c010 0 2 00000000 00400ff0 0 4 00400ff0 0
# 4m page in entry 2
1 60 68 1 2 40000 1c000 1 2 00000000 40123400 1 5 40123400 0
# unmapped address gets the refill tag
1 60 68 0 0 00000 00000 0 2 00000000 00500000 0 3 00500000 1
# paging off, misaligned branch target
0 00 00 0 0 00000 00000 0 1 1c000202 00000000 0 2 1c000202 2
# back to the boot stream
0 00 00 0 0 00000 00000 0 2 00000000 1c000000 2 10 1c000000 0

// ==== sim.f ====
source/fetch_pkg.sv
source/inst_tlb.sv
source/fetch_xlate.sv
source/fetch_stage.sv
source/fetch_top.sv
dv/fetch_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module fetch_tb -o fetch_sim
	./obj_dir/fetch_sim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
